// ==== Makefile ====
BIN := obj_dir/Vtb_xgmii_rx
SRCS := $(shell cat filelist.f)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f \
		--top-module tb_xgmii_rx -Mdir obj_dir

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== common/rx_pkg.sv ====
`default_nettype none

package rx_pkg;

	// --------------------
	// word layout
	// --------------------
	localparam int CTL_W = 8;
	localparam int DATA_W = 64;
	// control lanes sit above the data in a FIFO entry
	localparam int WORD_W = CTL_W + DATA_W;

	// all lanes control, no frame on the wire
	localparam logic [CTL_W-1:0] XGMII_IDLE_CTL = 8'hff;

	// --------------------
	// frame filter
	// --------------------
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0] IP_PROTO_UDP = 8'h11;
	localparam logic [15:0] UDP_DPORT = 16'd3422;
	localparam logic [31:0] MAGIC_CODE = 32'h3c4d5e6f;

	// byte offsets from the first destination MAC byte, and field lengths
	localparam int DMAC_POS = 0;
	localparam int DMAC_LEN = 6;
	localparam int ETYPE_POS = 12;
	localparam int ETYPE_LEN = 2;
	localparam int PROTO_POS = 23;
	localparam int PROTO_LEN = 1;
	localparam int DIP_POS = 30;
	localparam int DIP_LEN = 4;
	localparam int DPORT_POS = 36;
	localparam int DPORT_LEN = 2;
	localparam int MAGIC_POS = 42;
	localparam int MAGIC_LEN = 4;

	// word index saturates at the first payload word
	localparam int WIDX_W = 3;
	localparam logic [WIDX_W-1:0] HDR_LAST_WORD = 3'd6;
	localparam logic [WIDX_W-1:0] PAYLOAD_IDX = 3'd7;

	// --------------------
	// buffering and stats
	// --------------------
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;
	localparam int CNT_W = 8;

endpackage

`default_nettype wire

// ==== common/rx_word_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rx_word_if;
	import rx_pkg::*;

	logic valid;
	logic ready;
	logic [CTL_W-1:0] rxc;
	logic [DATA_W-1:0] rxd;

	// engine side
	modport src (
		output valid,
		output rxc,
		output rxd,
		input ready
	);

	// buffer side
	modport dst (
		input valid,
		input rxc,
		input rxd,
		output ready
	);

endinterface

`default_nettype wire

// ==== filelist.f ====
common/rx_pkg.sv
common/rx_word_if.sv
rx_engine/xgmii_rx_engine.sv
src/rx_word_fifo.sv
src/xgmii_rx_top.sv
sim/tb_xgmii_rx.sv

// ==== rx_engine/xgmii_rx_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module xgmii_rx_engine (
	input logic xgmii_clk,
	input logic sys_rst,
	input logic [rx_pkg::CTL_W-1:0] xgmii_rxc,
	input logic [rx_pkg::DATA_W-1:0] xgmii_rxd,
	input logic [47:0] if_macaddr,
	input logic [31:0] if_v4addr,
	rx_word_if.src wr,
	output logic [rx_pkg::CNT_W-1:0] pkt_count,
	output logic [rx_pkg::CNT_W-1:0] drop_count,
	output logic [7:0] led
);
	import rx_pkg::*;

	function automatic logic in_field(input int n, input int pos, input int len);
		return (n >= pos) && (n < pos + len);
	endfunction

	// big endian puts the first byte of a field in its top bits
	function automatic int field_off(input int n, input int pos, input int len);
		return 8 * (len - 1 - (n - pos));
	endfunction

	logic frame_idle;
	logic hdr_cycle;
	logic hdr_match;
	logic offer_fail;
	logic wr_take;
	logic [WIDX_W-1:0] word_idx;
	logic accepted;
	logic dropped;
	logic end_seen;
	logic end_pkt;
	logic end_drop;
	logic [CNT_W-1:0] frame_count;

	logic [47:0] dmac_q, dmac_nxt;
	logic [15:0] etype_q, etype_nxt;
	logic [7:0] proto_q, proto_nxt;
	logic [31:0] dip_q, dip_nxt;
	logic [15:0] dport_q, dport_nxt;
	logic [31:0] magic_q, magic_nxt;

	assign frame_idle = (xgmii_rxc == XGMII_IDLE_CTL);
	assign hdr_cycle = !frame_idle && (word_idx != '0) && (word_idx <= HDR_LAST_WORD);
	// a refused word on the bus drops the rest of the frame
	assign offer_fail = wr.valid && !wr.ready;
	assign wr_take = !frame_idle && (word_idx == PAYLOAD_IDX) && accepted && !dropped &&
		!offer_fail;

	// --------------------
	// header capture
	// --------------------
	always_comb begin
		int n;
		logic [7:0] b;
		dmac_nxt = dmac_q;
		etype_nxt = etype_q;
		proto_nxt = proto_q;
		dip_nxt = dip_q;
		dport_nxt = dport_q;
		magic_nxt = magic_q;
		for (int l = 0; l < CTL_W; l++) begin
			n = (int'(word_idx) - 1) * 8 + l;
			b = xgmii_rxd[8 * l +: 8];
			if (hdr_cycle) begin
				if (in_field(n, DMAC_POS, DMAC_LEN))
					dmac_nxt[field_off(n, DMAC_POS, DMAC_LEN) +: 8] = b;
				if (in_field(n, ETYPE_POS, ETYPE_LEN))
					etype_nxt[field_off(n, ETYPE_POS, ETYPE_LEN) +: 8] = b;
				if (in_field(n, PROTO_POS, PROTO_LEN))
					proto_nxt[field_off(n, PROTO_POS, PROTO_LEN) +: 8] = b;
				if (in_field(n, DIP_POS, DIP_LEN))
					dip_nxt[field_off(n, DIP_POS, DIP_LEN) +: 8] = b;
				if (in_field(n, DPORT_POS, DPORT_LEN))
					dport_nxt[field_off(n, DPORT_POS, DPORT_LEN) +: 8] = b;
				if (in_field(n, MAGIC_POS, MAGIC_LEN))
					magic_nxt[field_off(n, MAGIC_POS, MAGIC_LEN) +: 8] = b;
			end
		end
	end

	// magic arrives in the decision word itself so the match reads the _nxt values
	assign hdr_match = (dmac_nxt == if_macaddr) && (etype_nxt == ETH_TYPE_IPV4) &&
		(proto_nxt == IP_PROTO_UDP) && (dip_nxt == if_v4addr) &&
		(dport_nxt == UDP_DPORT) && (magic_nxt == MAGIC_CODE);

	always_ff @(posedge xgmii_clk) begin
		dmac_q <= dmac_nxt;
		etype_q <= etype_nxt;
		proto_q <= proto_nxt;
		dip_q <= dip_nxt;
		dport_q <= dport_nxt;
		magic_q <= magic_nxt;
	end

	// --------------------
	// frame state, payload
	// --------------------
	always_ff @(posedge xgmii_clk) begin
		if (sys_rst) begin
			word_idx <= '0;
			accepted <= 1'b0;
			dropped <= 1'b0;
			end_seen <= 1'b0;
			end_pkt <= 1'b0;
			end_drop <= 1'b0;
			wr.valid <= 1'b0;
		end else begin
			end_seen <= 1'b0;
			end_pkt <= 1'b0;
			end_drop <= 1'b0;
			wr.valid <= wr_take;
			if (frame_idle) begin
				// last offered word is still judged on this edge
				if (word_idx != '0) begin
					end_seen <= 1'b1;
					end_pkt <= accepted && !dropped && !offer_fail;
					end_drop <= accepted && (dropped || offer_fail);
				end
				word_idx <= '0;
				accepted <= 1'b0;
				dropped <= 1'b0;
			end else begin
				if (word_idx != PAYLOAD_IDX)
					word_idx <= word_idx + 1'b1;
				if (word_idx == HDR_LAST_WORD)
					accepted <= hdr_match;
				if (offer_fail)
					dropped <= 1'b1;
			end
		end
	end

	always_ff @(posedge xgmii_clk) begin
		if (wr_take) begin
			wr.rxc <= xgmii_rxc;
			wr.rxd <= xgmii_rxd;
		end
	end

	// --------------------
	// frame counters
	// --------------------
	always_ff @(posedge xgmii_clk) begin
		if (sys_rst) begin
			pkt_count <= '0;
			drop_count <= '0;
			frame_count <= '0;
		end else if (end_seen) begin
			frame_count <= frame_count + 1'b1;
			if (end_pkt)
				pkt_count <= pkt_count + 1'b1;
			if (end_drop)
				drop_count <= drop_count + 1'b1;
		end
	end

	assign led = frame_count[7:0];

	// only payload of an accepted frame reaches the buffer
	a_valid_in_accepted: assert property (@(posedge xgmii_clk) disable iff (sys_rst)
		wr.valid |-> (accepted && word_idx == PAYLOAD_IDX));

	// nothing more of a dropped frame is offered
	a_no_valid_after_drop: assert property (@(posedge xgmii_clk) disable iff (sys_rst)
		dropped |-> !wr.valid);

endmodule

`default_nettype wire

// ==== sim/tb_xgmii_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_xgmii_rx;
	import rx_pkg::*;

	typedef struct packed {
		logic mac_ok;
		logic [15:0] etype;
		logic [7:0] proto;
		logic ip_ok;
		logic [15:0] port;
		logic [31:0] magic;
		logic [7:0] len;
		logic hold_low;
		logic accept;
	} frame_t;

	localparam int N_FRAMES = 10;
	localparam logic [47:0] MY_MAC = 48'h021a2b3c4d5e;
	localparam logic [31:0] MY_IP = 32'hc0a80a02;
	localparam logic [63:0] IDLE_D = 64'h0707070707070707;

	logic xgmii_clk = 1'b0;
	logic sys_rst;
	logic [CTL_W-1:0] xgmii_rxc;
	logic [DATA_W-1:0] xgmii_rxd;
	logic [47:0] if_macaddr;
	logic [31:0] if_v4addr;
	logic m_valid;
	logic m_ready;
	logic [WORD_W-1:0] m_data;
	logic [CNT_W-1:0] pkt_count;
	logic [CNT_W-1:0] drop_count;
	logic [7:0] led;

	frame_t tbl [N_FRAMES];
	logic [WORD_W-1:0] exp_q [$];
	logic [7:0] exp_pkt = '0;
	logic [7:0] exp_drop = '0;
	logic [7:0] exp_frames = '0;
	integer seed = 32'h93617972;
	int cycles = 0;
	int limit = 0;

	xgmii_rx_top dut (
		.xgmii_clk (xgmii_clk),
		.sys_rst (sys_rst),
		.xgmii_rxc (xgmii_rxc),
		.xgmii_rxd (xgmii_rxd),
		.if_macaddr (if_macaddr),
		.if_v4addr (if_v4addr),
		.m_valid (m_valid),
		.m_ready (m_ready),
		.m_data (m_data),
		.pkt_count (pkt_count),
		.drop_count (drop_count),
		.led (led)
	);

	always #2 xgmii_clk = ~xgmii_clk;

	task automatic check_val(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
		input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			$display("test failed");
			$fatal(1, "value check failed");
		end
	endtask

	// one cycle on the wire, m_ready random unless held low
	task automatic put_word(input logic [7:0] c, input logic [63:0] d, input logic hold);
		logic [31:0] rb;
		rb = $random(seed);
		@(posedge xgmii_clk);
		xgmii_rxc <= c;
		xgmii_rxd <= d;
		m_ready <= hold ? 1'b0 : rb[0];
	endtask

	// --------------------
	// frame builder
	// --------------------
	task automatic send_frame(input frame_t f);
		logic [7:0] hdr [48];
		logic [47:0] mac;
		logic [31:0] ip;
		logic [63:0] d;
		logic [7:0] c;
		mac = f.mac_ok ? MY_MAC : MY_MAC ^ 48'h1;
		ip = f.ip_ok ? MY_IP : MY_IP ^ 32'h100;
		for (int i = 0; i < 48; i++)
			hdr[i] = 8'h40 + 8'(i);
		for (int i = 0; i < 6; i++)
			hdr[i] = mac[8 * (5 - i) +: 8];
		hdr[12] = f.etype[15:8];
		hdr[13] = f.etype[7:0];
		hdr[23] = f.proto;
		for (int i = 0; i < 4; i++)
			hdr[30 + i] = ip[8 * (3 - i) +: 8];
		hdr[36] = f.port[15:8];
		hdr[37] = f.port[7:0];
		for (int i = 0; i < 4; i++)
			hdr[42 + i] = f.magic[8 * (3 - i) +: 8];
		// preamble and SFD, start character in lane 0
		put_word(8'h01, 64'hd5555555555555fb, f.hold_low);
		for (int w = 0; w < 6; w++) begin
			for (int l = 0; l < 8; l++)
				d[8 * l +: 8] = hdr[8 * w + l];
			put_word(8'h00, d, f.hold_low);
		end
		for (int p = 0; p < int'(f.len); p++) begin
			c = (p == int'(f.len) - 1) ? 8'hf8 : 8'h00;
			d[31:0] = $random(seed);
			d[63:32] = $random(seed);
			put_word(c, d, f.hold_low);
			// a stalled consumer only gets what fits in the FIFO
			if (f.accept && (!f.hold_low || p < FIFO_DEPTH))
				exp_q.push_back({c, d});
		end
		if (f.accept) begin
			if (f.hold_low && int'(f.len) > FIFO_DEPTH)
				exp_drop = exp_drop + 1'b1;
			else
				exp_pkt = exp_pkt + 1'b1;
		end
		exp_frames = exp_frames + 1'b1;
	endtask

	// idle until the FIFO is empty, then the gap
	task automatic end_frame();
		@(posedge xgmii_clk);
		xgmii_rxc <= XGMII_IDLE_CTL;
		xgmii_rxd <= IDLE_D;
		m_ready <= 1'b1;
		while (m_valid || exp_q.size() != 0)
			@(negedge xgmii_clk);
		repeat (4) @(posedge xgmii_clk);
		@(negedge xgmii_clk);
		check_val(WORD_W'(pkt_count), WORD_W'(exp_pkt), "pkt_count");
		check_val(WORD_W'(drop_count), WORD_W'(exp_drop), "drop_count");
		check_val(WORD_W'(led), WORD_W'(exp_frames), "led");
	endtask

	// --------------------
	// output monitor
	// --------------------
	always @(posedge xgmii_clk) begin
		if (!sys_rst && m_valid && m_ready) begin
			if (exp_q.size() == 0) begin
				$display("an extra word %h left the FIFO at %0t", m_data, $time);
				$display("test failed");
				$fatal(1, "no expected word left");
			end else begin
				check_val(m_data, exp_q.pop_front(), "payload word");
			end
		end
	end

	always @(posedge xgmii_clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("the run did not finish within %0d cycles", limit);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		sys_rst = 1'b1;
		xgmii_rxc = XGMII_IDLE_CTL;
		xgmii_rxd = IDLE_D;
		if_macaddr = MY_MAC;
		if_v4addr = MY_IP;
		m_ready = 1'b0;
		// mac, etype, proto, ip, port, magic, len, hold low, accept
		tbl[0] = '{1'b1, ETH_TYPE_IPV4, IP_PROTO_UDP, 1'b1, UDP_DPORT, MAGIC_CODE, 8'd5, 1'b0, 1'b1};
		tbl[1] = '{1'b0, ETH_TYPE_IPV4, IP_PROTO_UDP, 1'b1, UDP_DPORT, MAGIC_CODE, 8'd4, 1'b0, 1'b0};
		tbl[2] = '{1'b1, 16'h86dd, IP_PROTO_UDP, 1'b1, UDP_DPORT, MAGIC_CODE, 8'd4, 1'b0, 1'b0};
		tbl[3] = '{1'b1, ETH_TYPE_IPV4, 8'h06, 1'b1, UDP_DPORT, MAGIC_CODE, 8'd4, 1'b0, 1'b0};
		tbl[4] = '{1'b1, ETH_TYPE_IPV4, IP_PROTO_UDP, 1'b0, UDP_DPORT, MAGIC_CODE, 8'd4, 1'b0, 1'b0};
		tbl[5] = '{1'b1, ETH_TYPE_IPV4, IP_PROTO_UDP, 1'b1, 16'd3423, MAGIC_CODE, 8'd4, 1'b0, 1'b0};
		tbl[6] = '{1'b1, ETH_TYPE_IPV4, IP_PROTO_UDP, 1'b1, UDP_DPORT, 32'h3c4d5e60, 8'd4, 1'b0, 1'b0};
		tbl[7] = '{1'b1, ETH_TYPE_IPV4, IP_PROTO_UDP, 1'b1, UDP_DPORT, MAGIC_CODE, 8'd10, 1'b0, 1'b1};
		tbl[8] = '{1'b1, ETH_TYPE_IPV4, IP_PROTO_UDP, 1'b1, UDP_DPORT, MAGIC_CODE, 8'd20, 1'b1, 1'b1};
		tbl[9] = '{1'b1, ETH_TYPE_IPV4, IP_PROTO_UDP, 1'b1, UDP_DPORT, MAGIC_CODE, 8'd6, 1'b0, 1'b1};
		for (int i = 0; i < N_FRAMES; i++)
			limit = limit + 40 * int'(tbl[i].len);
		limit = limit + 200;

		repeat (16) @(posedge xgmii_clk);
		sys_rst <= 1'b0;
		@(negedge xgmii_clk);
		check_val(WORD_W'(m_valid), '0, "m_valid after reset");
		check_val(WORD_W'(pkt_count), '0, "pkt_count after reset");
		check_val(WORD_W'(drop_count), '0, "drop_count after reset");
		check_val(WORD_W'(led), '0, "led after reset");

		for (int i = 0; i < N_FRAMES; i++) begin
			send_frame(tbl[i]);
			end_frame();
		end
		check_val(WORD_W'(led), WORD_W'(N_FRAMES % 256), "led at end");

		if (exp_q.size() == 0 && !m_valid) begin
			$display("test passed");
			$finish;
		end else begin
			$display("expected words were still waiting at the end of the run");
			$display("test failed");
			$fatal(1, "words left over");
		end
	end

endmodule

`default_nettype wire

// ==== src/rx_word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_word_fifo (
	input logic xgmii_clk,
	input logic sys_rst,
	rx_word_if.dst wr,
	output logic m_valid,
	input logic m_ready,
	output logic [rx_pkg::WORD_W-1:0] m_data
);
	import rx_pkg::*;

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;
	logic do_wr;
	logic do_rd;

	// --------------------
	// handshakes
	// --------------------
	assign wr.ready = (count != (FIFO_AW + 1)'(FIFO_DEPTH));
	assign do_wr = wr.valid && wr.ready;
	assign m_valid = (count != '0);
	assign do_rd = m_valid && m_ready;

	// head entry shows straight away, no output register
	assign m_data = mem[rd_ptr];

	always_ff @(posedge xgmii_clk) begin
		if (do_wr)
			mem[wr_ptr] <= {wr.rxc, wr.rxd};
	end

	// --------------------
	// pointers and count
	// --------------------
	always_ff @(posedge xgmii_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	a_count_bound: assert property (@(posedge xgmii_clk) disable iff (sys_rst)
		count <= (FIFO_AW + 1)'(FIFO_DEPTH));

	// stalled head word must not move or vanish
	a_hold_stalled: assert property (@(posedge xgmii_clk) disable iff (sys_rst)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_data)));

endmodule

`default_nettype wire

// ==== src/xgmii_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module xgmii_rx_top (
	input logic xgmii_clk,
	input logic sys_rst,
	input logic [rx_pkg::CTL_W-1:0] xgmii_rxc,
	input logic [rx_pkg::DATA_W-1:0] xgmii_rxd,
	input logic [47:0] if_macaddr,
	input logic [31:0] if_v4addr,
	output logic m_valid,
	input logic m_ready,
	output logic [rx_pkg::WORD_W-1:0] m_data,
	output logic [rx_pkg::CNT_W-1:0] pkt_count,
	output logic [rx_pkg::CNT_W-1:0] drop_count,
	output logic [7:0] led
);

	// payload words from parser to buffer
	rx_word_if wr_if ();

	// --------------------
	// parser and filter
	// --------------------
	xgmii_rx_engine u_engine (
		.xgmii_clk (xgmii_clk),
		.sys_rst (sys_rst),
		.xgmii_rxc (xgmii_rxc),
		.xgmii_rxd (xgmii_rxd),
		.if_macaddr (if_macaddr),
		.if_v4addr (if_v4addr),
		.wr (wr_if.src),
		.pkt_count (pkt_count),
		.drop_count (drop_count),
		.led (led)
	);

	// --------------------
	// payload buffer
	// --------------------
	rx_word_fifo u_fifo (
		.xgmii_clk (xgmii_clk),
		.sys_rst (sys_rst),
		.wr (wr_if.dst),
		.m_valid (m_valid),
		.m_ready (m_ready),
		.m_data (m_data)
	);

endmodule

`default_nettype wire
